/* source/wb_isa_pkg.sv */
package wb_isa_pkg;

  // RV32E has 16 integer registers
  localparam int REG_ADDR_W = 4;
  localparam int XLEN       = 32;
  localparam int CSR_ADDR_W = 12;

  // machine-mode CSR addresses
  localparam logic [CSR_ADDR_W-1:0] CSR_MSTATUS  = 12'h300;
  localparam logic [CSR_ADDR_W-1:0] CSR_MTVEC    = 12'h305;
  localparam logic [CSR_ADDR_W-1:0] CSR_MEPC     = 12'h341;
  localparam logic [CSR_ADDR_W-1:0] CSR_MCAUSE   = 12'h342;
  localparam logic [CSR_ADDR_W-1:0] CSR_MINSTRET = 12'hb02;

  // environment call from M-mode
  localparam logic [XLEN-1:0] CAUSE_ECALL_M = 32'd11;

endpackage

/* source/wb_pipe_pkg.sv */
package wb_pipe_pkg;

  // one retiring instruction from execute
  typedef struct packed {
    logic                                  wen;
    logic [wb_isa_pkg::REG_ADDR_W-1:0]     rd_addr;
    logic                                  csr_wen;
    logic [wb_isa_pkg::CSR_ADDR_W-1:0]     csr_addr;
    logic                                  brch;
    logic                                  jal;
    logic                                  jalr;
    logic                                  ecall;
    logic                                  mret;
    logic                                  ebreak;    // retired as a plain instruction
    logic [wb_isa_pkg::XLEN-1:0]           pc;
    logic [wb_isa_pkg::XLEN-1:0]           pc_next;   // computed target
    logic [wb_isa_pkg::XLEN-1:0]           res;
  } wb_req_t;

  typedef struct packed {
    logic                                  en;
    logic [wb_isa_pkg::REG_ADDR_W-1:0]     addr;
    logic [wb_isa_pkg::XLEN-1:0]           data;
  } rf_wr_t;

  typedef struct packed {
    logic                                  en;
    logic [wb_isa_pkg::CSR_ADDR_W-1:0]     addr;
    logic [wb_isa_pkg::XLEN-1:0]           data;
  } csr_wr_t;

  typedef struct packed {
    logic                                  ecall;
    logic                                  mret;
    logic                                  retire;    // one per strobe
    logic [wb_isa_pkg::XLEN-1:0]           pc;
  } trap_ev_t;

  typedef struct packed {
    logic                                  valid;
    logic [wb_isa_pkg::XLEN-1:0]           pc;
  } redirect_t;

endpackage

/* source/wb_unit.sv */
`timescale 1ns/10ps

module wb_unit (
  input  logic                              clock,
  input  logic                              reset,
  input  logic                              i_valid,
  input  wb_pipe_pkg::wb_req_t              i_req,
  input  logic [wb_isa_pkg::XLEN-1:0]       i_mtvec,
  input  logic [wb_isa_pkg::XLEN-1:0]       i_mepc,
  output wb_pipe_pkg::rf_wr_t               o_rf_wr,
  output wb_pipe_pkg::csr_wr_t              o_csr_wr,
  output wb_pipe_pkg::trap_ev_t             o_trap,
  output wb_pipe_pkg::redirect_t            o_redirect
);

  logic                          rd_nonzero;
  logic                          jump;
  logic                          take;
  logic [wb_isa_pkg::XLEN-1:0]   target;

  assign rd_nonzero = |i_req.rd_addr;

  // register write, lands at the edge that samples the strobe
  always_comb begin
    o_rf_wr.en   = i_valid & i_req.wen & rd_nonzero;   // x0 never written
    o_rf_wr.addr = i_req.rd_addr;
    o_rf_wr.data = i_req.res;
  end

  // csr write carries the final value from execute
  always_comb begin
    o_csr_wr.en   = i_valid & i_req.csr_wen;
    o_csr_wr.addr = i_req.csr_addr;
    o_csr_wr.data = i_req.res;
  end

  always_comb begin
    o_trap.ecall  = i_valid & i_req.ecall;
    o_trap.mret   = i_valid & i_req.mret;
    o_trap.retire = i_valid;
    o_trap.pc     = i_req.pc;
  end

  assign jump = i_req.brch | i_req.jal | i_req.jalr;
  assign take = i_valid & (jump | i_req.ecall | i_req.mret);

  // trap entry first, then return, then plain control flow
  always_comb begin
    if (i_req.ecall) begin
      target = i_mtvec;
    end else if (i_req.mret) begin
      target = i_mepc;
    end else begin
      target = i_req.pc_next;
    end
  end

  // one-cycle redirect strobe, no back-pressure
  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      o_redirect.valid <= 1'b0;
      o_redirect.pc    <= '0;
    end else begin
      o_redirect.valid <= take;
      if (take) begin
        o_redirect.pc <= target;
      end
    end
  end

endmodule

/* source/wb_csr_file.sv */
`timescale 1ns/10ps

module wb_csr_file (
  input  logic                                  clock,
  input  logic                                  reset,
  input  wb_pipe_pkg::csr_wr_t                  i_csr_wr,
  input  wb_pipe_pkg::trap_ev_t                 i_trap,
  input  logic [wb_isa_pkg::CSR_ADDR_W-1:0]     i_csr_raddr,
  output logic [wb_isa_pkg::XLEN-1:0]           o_csr_rdata,
  output logic [wb_isa_pkg::XLEN-1:0]           o_mtvec,
  output logic [wb_isa_pkg::XLEN-1:0]           o_mepc
);

  logic [wb_isa_pkg::XLEN-1:0]   mstatus;
  logic [wb_isa_pkg::XLEN-1:0]   mtvec;
  logic [wb_isa_pkg::XLEN-1:0]   mepc;
  logic [wb_isa_pkg::XLEN-1:0]   mcause;
  logic [wb_isa_pkg::XLEN-1:0]   minstret;

  logic                          we_mstatus;
  logic                          we_mtvec;
  logic                          we_mepc;
  logic                          we_mcause;
  logic                          we_minstret;

  // write address decode, unknown addresses fall through
  always_comb begin
    we_mstatus  = 1'b0;
    we_mtvec    = 1'b0;
    we_mepc     = 1'b0;
    we_mcause   = 1'b0;
    we_minstret = 1'b0;
    if (i_csr_wr.en) begin
      case (i_csr_wr.addr)
        wb_isa_pkg::CSR_MSTATUS:  we_mstatus  = 1'b1;
        wb_isa_pkg::CSR_MTVEC:    we_mtvec    = 1'b1;
        wb_isa_pkg::CSR_MEPC:     we_mepc     = 1'b1;
        wb_isa_pkg::CSR_MCAUSE:   we_mcause   = 1'b1;
        wb_isa_pkg::CSR_MINSTRET: we_minstret = 1'b1;
        default: ;
      endcase
    end
  end

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      mstatus <= '0;
    end else if (we_mstatus) begin
      mstatus <= i_csr_wr.data;
    end
  end

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      mtvec <= '0;
    end else if (we_mtvec) begin
      mtvec <= i_csr_wr.data;
    end
  end

  // trap entry records the faulting pc
  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      mepc <= '0;
    end else if (i_trap.ecall) begin
      mepc <= i_trap.pc;
    end else if (we_mepc) begin
      mepc <= i_csr_wr.data;
    end
  end

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      mcause <= '0;
    end else if (i_trap.ecall) begin
      mcause <= wb_isa_pkg::CAUSE_ECALL_M;
    end else if (we_mcause) begin
      mcause <= i_csr_wr.data;
    end
  end

  // explicit write wins over the retire count
  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      minstret <= '0;
    end else if (we_minstret) begin
      minstret <= i_csr_wr.data;
    end else if (i_trap.retire) begin
      minstret <= minstret + 1'b1;
    end
  end

  always_comb begin
    case (i_csr_raddr)
      wb_isa_pkg::CSR_MSTATUS:  o_csr_rdata = mstatus;
      wb_isa_pkg::CSR_MTVEC:    o_csr_rdata = mtvec;
      wb_isa_pkg::CSR_MEPC:     o_csr_rdata = mepc;
      wb_isa_pkg::CSR_MCAUSE:   o_csr_rdata = mcause;
      wb_isa_pkg::CSR_MINSTRET: o_csr_rdata = minstret;
      default:                  o_csr_rdata = '0;
    endcase
  end

  assign o_mtvec = mtvec;   // ecall target
  assign o_mepc  = mepc;    // mret target

endmodule

/* source/wb_regfile.sv */
`timescale 1ns/10ps

module wb_regfile (
  input  logic                                  clock,
  input  logic                                  reset,
  input  wb_pipe_pkg::rf_wr_t                   i_wr,
  input  logic [wb_isa_pkg::REG_ADDR_W-1:0]     i_rs1_addr,
  input  logic [wb_isa_pkg::REG_ADDR_W-1:0]     i_rs2_addr,
  output logic [wb_isa_pkg::XLEN-1:0]           o_rs1_data,
  output logic [wb_isa_pkg::XLEN-1:0]           o_rs2_data
);

  logic [wb_isa_pkg::XLEN-1:0] regs [2**wb_isa_pkg::REG_ADDR_W];

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      for (int i = 0; i < 2**wb_isa_pkg::REG_ADDR_W; i++) begin
        regs[i] <= '0;
      end
    end else if (i_wr.en) begin
      regs[i_wr.addr] <= i_wr.data;
    end
  end

  // x0 is hardwired to zero
  always_comb begin
    if (i_rs1_addr == '0) begin
      o_rs1_data = '0;
    end else begin
      o_rs1_data = regs[i_rs1_addr];
    end
  end

  always_comb begin
    if (i_rs2_addr == '0) begin
      o_rs2_data = '0;
    end else begin
      o_rs2_data = regs[i_rs2_addr];
    end
  end

endmodule

/* source/wb_subsystem.sv */
`timescale 1ns/10ps

module wb_subsystem (
  input  logic                                  clock,
  input  logic                                  reset,
  input  logic                                  i_valid,
  input  wb_pipe_pkg::wb_req_t                  i_req,
  input  logic [wb_isa_pkg::REG_ADDR_W-1:0]     i_rs1_addr,
  input  logic [wb_isa_pkg::REG_ADDR_W-1:0]     i_rs2_addr,
  input  logic [wb_isa_pkg::CSR_ADDR_W-1:0]     i_csr_raddr,
  output logic [wb_isa_pkg::XLEN-1:0]           o_rs1_data,
  output logic [wb_isa_pkg::XLEN-1:0]           o_rs2_data,
  output logic [wb_isa_pkg::XLEN-1:0]           o_csr_rdata,
  output wb_pipe_pkg::redirect_t                o_redirect
);

  wb_pipe_pkg::rf_wr_t           rf_wr;
  wb_pipe_pkg::csr_wr_t          csr_wr;
  wb_pipe_pkg::trap_ev_t         trap;
  logic [wb_isa_pkg::XLEN-1:0]   mtvec;
  logic [wb_isa_pkg::XLEN-1:0]   mepc;

  wb_unit wb_unit_i (
    .clock      (clock),
    .reset      (reset),
    .i_valid    (i_valid),
    .i_req      (i_req),
    .i_mtvec    (mtvec),
    .i_mepc     (mepc),
    .o_rf_wr    (rf_wr),
    .o_csr_wr   (csr_wr),
    .o_trap     (trap),
    .o_redirect (o_redirect)
  );

  wb_csr_file wb_csr_file_i (
    .clock       (clock),
    .reset       (reset),
    .i_csr_wr    (csr_wr),
    .i_trap      (trap),
    .i_csr_raddr (i_csr_raddr),
    .o_csr_rdata (o_csr_rdata),
    .o_mtvec     (mtvec),
    .o_mepc      (mepc)
  );

  wb_regfile wb_regfile_i (
    .clock      (clock),
    .reset      (reset),
    .i_wr       (rf_wr),
    .i_rs1_addr (i_rs1_addr),
    .i_rs2_addr (i_rs2_addr),
    .o_rs1_data (o_rs1_data),
    .o_rs2_data (o_rs2_data)
  );

endmodule

/* dv/wb_tb.sv */
`timescale 1ns/10ps

module wb_tb;

  localparam int RESET_CYCLES = 4;
  localparam int N_IDLE       = 8;
  localparam int N_REG        = 200;
  localparam int N_CSR        = 150;
  localparam int N_JMP        = 100;
  localparam int N_DIRECTED   = 24;
  localparam int N_MIX        = 300;
  localparam int MAX_CYCLES   = RESET_CYCLES + N_IDLE + N_REG + N_CSR + N_JMP
                                + N_DIRECTED + N_MIX + 50;   // margin

  localparam int K_PLAIN  = 0;
  localparam int K_CSR    = 1;
  localparam int K_BRCH   = 2;
  localparam int K_JAL    = 3;
  localparam int K_JALR   = 4;
  localparam int K_ECALL  = 5;
  localparam int K_MRET   = 6;
  localparam int K_EBREAK = 7;

  logic                                clock;
  logic                                reset;
  logic                                i_valid;
  wb_pipe_pkg::wb_req_t                i_req;
  logic [wb_isa_pkg::REG_ADDR_W-1:0]   i_rs1_addr;
  logic [wb_isa_pkg::REG_ADDR_W-1:0]   i_rs2_addr;
  logic [wb_isa_pkg::CSR_ADDR_W-1:0]   i_csr_raddr;
  logic [31:0]                         o_rs1_data;
  logic [31:0]                         o_rs2_data;
  logic [31:0]                         o_csr_rdata;
  wb_pipe_pkg::redirect_t              o_redirect;

  logic [31:0] rng;
  int          errors;
  int          checks;
  int          cycles;

  // reference model state
  logic [31:0] m_regs [16];
  logic [31:0] m_mstatus;
  logic [31:0] m_mtvec;
  logic [31:0] m_mepc;
  logic [31:0] m_mcause;
  logic [31:0] m_minstret;
  logic        exp_redir_valid;
  logic [31:0] exp_redir_pc;

  wb_subsystem wb_subsystem_i (
    .clock       (clock),
    .reset       (reset),
    .i_valid     (i_valid),
    .i_req       (i_req),
    .i_rs1_addr  (i_rs1_addr),
    .i_rs2_addr  (i_rs2_addr),
    .i_csr_raddr (i_csr_raddr),
    .o_rs1_data  (o_rs1_data),
    .o_rs2_data  (o_rs2_data),
    .o_csr_rdata (o_csr_rdata),
    .o_redirect  (o_redirect)
  );

  always #20 clock = ~clock;

  always @(posedge clock) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout: the test did not finish within %0d cycles", MAX_CYCLES);
      $display("Errors found");
      $finish;
    end
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] rand32();
    rng = xorshift32(rng);
    return rng;
  endfunction

  task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Error %s: got %h expected %h", name, got, exp);
    end
  endtask

  function automatic logic [31:0] model_csr(input logic [11:0] addr);
    case (addr)
      wb_isa_pkg::CSR_MSTATUS:  return m_mstatus;
      wb_isa_pkg::CSR_MTVEC:    return m_mtvec;
      wb_isa_pkg::CSR_MEPC:     return m_mepc;
      wb_isa_pkg::CSR_MCAUSE:   return m_mcause;
      wb_isa_pkg::CSR_MINSTRET: return m_minstret;
      default:                  return 32'h0;
    endcase
  endfunction

  // state change at the edge that samples the strobe
  task automatic model_step(input logic v, input wb_pipe_pkg::wb_req_t r);
    logic cnt_written;
    cnt_written = 1'b0;
    exp_redir_valid = v & (r.brch | r.jal | r.jalr | r.ecall | r.mret);
    if (exp_redir_valid) begin
      if (r.ecall) exp_redir_pc = m_mtvec;   // values before the edge
      else if (r.mret) exp_redir_pc = m_mepc;
      else exp_redir_pc = r.pc_next;
    end
    if (v) begin
      if (r.wen && r.rd_addr != '0) m_regs[r.rd_addr] = r.res;
      if (r.csr_wen) begin
        case (r.csr_addr)
          wb_isa_pkg::CSR_MSTATUS:  m_mstatus = r.res;
          wb_isa_pkg::CSR_MTVEC:    m_mtvec   = r.res;
          wb_isa_pkg::CSR_MEPC:     m_mepc    = r.res;
          wb_isa_pkg::CSR_MCAUSE:   m_mcause  = r.res;
          wb_isa_pkg::CSR_MINSTRET: begin
            m_minstret  = r.res;
            cnt_written = 1'b1;
          end
          default: ;
        endcase
      end
      if (r.ecall) begin
        m_mepc   = r.pc;
        m_mcause = 32'd11;
      end
      if (!cnt_written) m_minstret = m_minstret + 32'd1;
    end
  endtask

  // drive at edge + 2, check at the falling edge, then advance the model
  task automatic run_cycle(input logic v, input wb_pipe_pkg::wb_req_t r,
                           input logic [3:0] a1, input logic [3:0] a2, input logic [11:0] ca);
    i_valid     = v;
    i_req       = r;
    i_rs1_addr  = a1;
    i_rs2_addr  = a2;
    i_csr_raddr = ca;
    @(negedge clock);
    compare("o_rs1_data", o_rs1_data, m_regs[a1]);
    compare("o_rs2_data", o_rs2_data, m_regs[a2]);
    compare("o_csr_rdata", o_csr_rdata, model_csr(ca));
    compare("o_redirect.valid", {31'b0, o_redirect.valid}, {31'b0, exp_redir_valid});
    if (exp_redir_valid) compare("o_redirect.pc", o_redirect.pc, exp_redir_pc);
    @(posedge clock);
    model_step(v, r);
    #2;
  endtask

  task automatic pick_csr(output logic [11:0] a);
    logic [31:0] x;
    x = rand32();
    case (x[2:0])
      3'd0:    a = wb_isa_pkg::CSR_MSTATUS;
      3'd1:    a = wb_isa_pkg::CSR_MTVEC;
      3'd2:    a = wb_isa_pkg::CSR_MEPC;
      3'd3:    a = wb_isa_pkg::CSR_MCAUSE;
      3'd4:    a = wb_isa_pkg::CSR_MINSTRET;
      default: a = x[15:4];   // mostly unknown addresses
    endcase
  endtask

  task automatic build_req(input int kind, output wb_pipe_pkg::wb_req_t r);
    logic [31:0] x;
    logic [11:0] ca;
    r = '0;
    x = rand32();
    r.rd_addr = x[3:0];
    r.wen     = x[4];
    x = rand32();
    r.pc = {x[31:2], 2'b00};
    x = rand32();
    r.pc_next = {x[31:2], 2'b00};
    r.res = rand32();
    case (kind)
      K_CSR: begin
        pick_csr(ca);
        r.csr_wen  = 1'b1;
        r.csr_addr = ca;
      end
      K_BRCH:   r.brch   = 1'b1;
      K_JAL:    r.jal    = 1'b1;
      K_JALR:   r.jalr   = 1'b1;
      K_ECALL: begin
        r.ecall = 1'b1;
        r.wen   = 1'b0;
      end
      K_MRET: begin
        r.mret = 1'b1;
        r.wen  = 1'b0;
      end
      K_EBREAK: r.ebreak = 1'b1;
      default: ;
    endcase
  endtask

  task automatic random_cycle(input int kind);
    wb_pipe_pkg::wb_req_t r;
    logic [31:0] x;
    logic [11:0] ca;
    build_req(kind, r);
    pick_csr(ca);
    x = rand32();
    run_cycle(x[1:0] != 2'b00, r, x[7:4], x[11:8], ca);   // strobe 3 cycles in 4
  endtask

  task automatic directed(input int kind, input logic [11:0] csr_addr,
                          input logic [31:0] pc, input logic [31:0] value, input logic [11:0] ca);
    wb_pipe_pkg::wb_req_t r;
    build_req(kind, r);
    r.wen = 1'b0;
    if (kind == K_CSR) r.csr_addr = csr_addr;
    r.pc      = pc;
    r.pc_next = value;
    r.res     = value;
    run_cycle(1'b1, r, 4'd0, 4'd0, ca);
  endtask

  initial begin
    wb_pipe_pkg::wb_req_t idle;
    logic [31:0] x;
    idle        = '0;
    clock       = 1'b0;
    reset       = 1'b1;
    i_valid     = 1'b0;
    i_req       = '0;
    i_rs1_addr  = '0;
    i_rs2_addr  = '0;
    i_csr_raddr = '0;
    rng         = 32'hf6a8;
    errors      = 0;
    checks      = 0;
    cycles      = 0;
    for (int i = 0; i < 16; i++) m_regs[i] = '0;
    m_mstatus       = '0;
    m_mtvec         = '0;
    m_mepc          = '0;
    m_mcause        = '0;
    m_minstret      = '0;
    exp_redir_valid = 1'b0;
    exp_redir_pc    = '0;

    repeat (RESET_CYCLES) @(posedge clock);
    #2;
    reset = 1'b0;

    // everything reads zero out of reset
    for (int i = 0; i < N_IDLE; i++) begin
      x = 32'(i);
      run_cycle(1'b0, idle, {x[2:0], 1'b0}, {x[2:0], 1'b1}, model_csr_addr(i));
    end

    for (int i = 0; i < N_REG; i++) random_cycle(K_PLAIN);
    for (int i = 0; i < N_CSR; i++) begin
      x = rand32();
      random_cycle(x[0] ? K_CSR : K_PLAIN);
    end
    for (int i = 0; i < N_JMP; i++) begin
      x = rand32();
      case (x[2:0])
        3'd0, 3'd1: random_cycle(K_BRCH);
        3'd2:       random_cycle(K_JAL);
        3'd3:       random_cycle(K_JALR);
        3'd4:       random_cycle(K_EBREAK);
        default:    random_cycle(K_PLAIN);
      endcase
    end

    // trap entry and return
    directed(K_CSR, wb_isa_pkg::CSR_MTVEC, 32'h0, 32'h0000_0400, wb_isa_pkg::CSR_MTVEC);
    directed(K_ECALL, 12'h0, 32'h0000_1234, 32'h0, wb_isa_pkg::CSR_MTVEC);
    run_cycle(1'b0, idle, 4'd0, 4'd0, wb_isa_pkg::CSR_MEPC);
    run_cycle(1'b0, idle, 4'd0, 4'd0, wb_isa_pkg::CSR_MCAUSE);
    directed(K_MRET, 12'h0, 32'h0000_0410, 32'h0, wb_isa_pkg::CSR_MEPC);
    run_cycle(1'b0, idle, 4'd0, 4'd0, wb_isa_pkg::CSR_MEPC);
    // back-to-back redirects
    directed(K_JAL, 12'h0, 32'h0000_2000, 32'h0000_3000, wb_isa_pkg::CSR_MINSTRET);
    directed(K_ECALL, 12'h0, 32'h0000_3000, 32'h0, wb_isa_pkg::CSR_MEPC);
    directed(K_MRET, 12'h0, 32'h0000_0400, 32'h0, wb_isa_pkg::CSR_MEPC);
    directed(K_BRCH, 12'h0, 32'h0000_3000, 32'h0000_5000, wb_isa_pkg::CSR_MCAUSE);
    run_cycle(1'b0, idle, 4'd0, 4'd0, wb_isa_pkg::CSR_MINSTRET);
    // retire count restarts from a written value
    directed(K_CSR, wb_isa_pkg::CSR_MINSTRET, 32'h0, 32'h0000_0100, wb_isa_pkg::CSR_MINSTRET);
    for (int i = 0; i < 6; i++) directed(K_PLAIN, 12'h0, 32'h0, 32'h0, wb_isa_pkg::CSR_MINSTRET);
    run_cycle(1'b0, idle, 4'd0, 4'd0, wb_isa_pkg::CSR_MINSTRET);

    for (int i = 0; i < N_MIX; i++) begin
      x = rand32();
      random_cycle(int'(x[2:0]));
    end
    run_cycle(1'b0, idle, 4'd0, 4'd0, wb_isa_pkg::CSR_MINSTRET);

    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

  function automatic logic [11:0] model_csr_addr(input int i);
    case (i % 6)
      0:       return wb_isa_pkg::CSR_MSTATUS;
      1:       return wb_isa_pkg::CSR_MTVEC;
      2:       return wb_isa_pkg::CSR_MEPC;
      3:       return wb_isa_pkg::CSR_MCAUSE;
      4:       return wb_isa_pkg::CSR_MINSTRET;
      default: return 12'h7c0;   // unknown
    endcase
  endfunction

endmodule

/* vlog.f */
source/wb_isa_pkg.sv
source/wb_pipe_pkg.sv
source/wb_unit.sv
source/wb_csr_file.sv
source/wb_regfile.sv
source/wb_subsystem.sv
dv/wb_tb.sv

/* Makefile */
SIM      := verilator
FLAGS    := --binary --timing -Wno-fatal
TOP      := wb_tb
FILELIST := vlog.f
OBJDIR   := obj_dir
PASS_MSG := No errors

BIN      := $(OBJDIR)/V$(TOP)
SOURCES  := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJDIR)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)
